/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_dram_dma
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q '^Verification passed$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* credit_fifo.sv */
`timescale 1ns/1ns

module credit_fifo
   import dram_dma_pkg::*;
#(
   parameter type payload_t = logic
)
(
   input  logic     clk,
   input  logic     sync_rst_n,
   input  logic     push,
   input  payload_t push_data,
   input  logic     pop,
   output payload_t pop_data,
   output logic     empty,
   output logic     credit
);

   payload_t                   buffer [CREDITS];
   logic [$clog2(CREDITS)-1:0] wr_ptr;
   logic [$clog2(CREDITS)-1:0] rd_ptr;
   credit_t                    count;
   logic                       full;
   logic                       do_pop;

   assign empty    = (count == '0);
   assign full     = (count == credit_t'(CREDITS));
   assign do_pop   = pop && !empty;
   assign pop_data = buffer[rd_ptr];
   // one credit back to the sender per entry freed
   assign credit   = do_pop;

   // pointers wrap on their own, depth is a power of two
   always_ff @(posedge clk or negedge sync_rst_n)
      if (!sync_rst_n)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_pop)
            rd_ptr <= rd_ptr + 1'b1;
         count <= count + credit_t'(push) - credit_t'(do_pop);
      end

   always_ff @(posedge clk)
      if (push)
         buffer[wr_ptr] <= push_data;

   // the sender's credit count must keep us from ever overflowing
   a_no_push_full: assert property (@(posedge clk) disable iff (!sync_rst_n)
      push |-> !full);

endmodule

/* ddr_channel.sv */
`timescale 1ns/1ns

module ddr_channel
   import dram_dma_pkg::*;
(
   input  logic      clk,
   input  logic      sync_rst_n,
   input  logic      cmd_valid,
   input  dram_cmd_t cmd,
   output logic      cmd_credit,
   input  logic      scrub_en,
   output logic      scrub_done,
   output word_t     scrub_addr,
   output logic      rsp_valid,
   output dram_rsp_t rsp,
   input  logic      rsp_credit
);

   data_t     mem [MEM_DEPTH];
   dram_cmd_t head;
   logic      fifo_empty;
   logic      scrubbing;
   logic      pop;
   logic      rd_pop;
   credit_t   rsp_credit_cnt;

   credit_fifo #(.payload_t(dram_cmd_t)) u_cmd_fifo (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .push       (cmd_valid),
      .push_data  (cmd),
      .pop        (pop),
      .pop_data   (head),
      .empty      (fifo_empty),
      .credit     (cmd_credit)
   );

   // scrubber owns the memory port until it is done
   assign scrubbing = scrub_en && !scrub_done;
   // a read needs a merge credit before it may leave the fifo
   assign pop    = !fifo_empty && !scrubbing && (head.write || rsp_credit_cnt != '0);
   assign rd_pop = pop && !head.write;

   // ---------------------------------------------------------------------
   // scrubber
   // ---------------------------------------------------------------------
   always_ff @(posedge clk or negedge sync_rst_n)
      if (!sync_rst_n)
      begin
         scrub_addr <= '0;
         scrub_done <= 1'b0;
      end
      else if (!scrub_en)
      begin
         scrub_addr <= '0;
         scrub_done <= 1'b0;
      end
      else if (scrubbing)
      begin
         // address parks on the last word once done
         if (scrub_addr == word_t'(MEM_DEPTH-1))
            scrub_done <= 1'b1;
         else
            scrub_addr <= scrub_addr + 1'b1;
      end

   always_ff @(posedge clk)
      if (scrubbing)
         mem[scrub_addr] <= '0;
      else if (pop && head.write)
         mem[head.word] <= head.data;

   // ---------------------------------------------------------------------
   // read response toward the merge
   // ---------------------------------------------------------------------
   always_ff @(posedge clk)
      if (rd_pop)
         rsp <= '{word: head.word, data: mem[head.word]};

   always_ff @(posedge clk or negedge sync_rst_n)
      if (!sync_rst_n)
      begin
         rsp_valid      <= 1'b0;
         rsp_credit_cnt <= credit_t'(CREDITS);
      end
      else
      begin
         rsp_valid      <= rd_pop;
         rsp_credit_cnt <= rsp_credit_cnt + credit_t'(rsp_credit) - credit_t'(rd_pop);
      end

endmodule

/* dma_cmd_router.sv */
`timescale 1ns/1ns

module dma_cmd_router
   import dram_dma_pkg::*;
(
   input  logic                clk,
   input  logic                sync_rst_n,
   input  logic                cmd_valid,
   input  logic                cmd_write,
   input  addr_t               cmd_addr,
   input  data_t               cmd_data,
   output logic                cmd_ready,
   output logic [NUM_CHAN-1:0] chan_valid,
   output dram_cmd_t           chan_cmd,
   input  logic [NUM_CHAN-1:0] chan_credit
);

   credit_t             credit_cnt [NUM_CHAN];
   chan_sel_t           sel;
   logic                accept;
   logic [NUM_CHAN-1:0] take;

   // top address bits pick the channel
   assign sel       = cmd_addr[ADDR_W-1 -: CHAN_SEL_W];
   assign cmd_ready = (credit_cnt[sel] != '0);
   assign accept    = cmd_valid && cmd_ready;

   always_comb
   begin
      take = '0;
      if (accept)
         take[sel] = 1'b1;
   end

   // ---------------------------------------------------------------------
   // per channel credit counters
   // ---------------------------------------------------------------------
   always_ff @(posedge clk or negedge sync_rst_n)
      if (!sync_rst_n)
      begin
         for (int i = 0; i < NUM_CHAN; i++)
            credit_cnt[i] <= credit_t'(CREDITS);
      end
      else
      begin
         for (int i = 0; i < NUM_CHAN; i++)
            credit_cnt[i] <= credit_cnt[i] + credit_t'(chan_credit[i]) - credit_t'(take[i]);
      end

   // registered send, lands in the channel fifo on the next edge
   always_ff @(posedge clk or negedge sync_rst_n)
      if (!sync_rst_n)
         chan_valid <= '0;
      else
         chan_valid <= take;

   always_ff @(posedge clk)
      if (accept)
         chan_cmd <= '{write: cmd_write, word: cmd_addr[WORD_W-1:0], data: cmd_data};

   for (genvar i = 0; i < NUM_CHAN; i++)
   begin : g_chk
      // a channel returning more credits than it was given is a protocol bug
      a_credit_bound: assert property (@(posedge clk) disable iff (!sync_rst_n)
         credit_cnt[i] <= credit_t'(CREDITS));
   end

endmodule

/* dram_ctl.sv */
`timescale 1ns/1ns

module dram_ctl
   import dram_dma_pkg::*;
(
   input  logic                clk,
   input  logic                sync_rst_n,
   input  logic [31:0]         ctl0,
   input  logic                flr_assert,
   output logic                flr_done,
   output logic [NUM_CHAN-1:0] scrub_en,
   input  logic [NUM_CHAN-1:0] scrub_done,
   input  word_t               scrub_addr [NUM_CHAN],
   output logic [31:0]         status0,
   output logic [31:0]         id0
);

   logic [31:0] ctl0_q;
   logic        flr_q;
   logic        dbg_en;
   chan_sel_t   dbg_sel;

   // low bits of ctl0 are the per channel scrub enables
   assign scrub_en = ctl0_q[NUM_CHAN-1:0];
   assign dbg_en   = ctl0_q[DBG_EN_BIT];
   // only the low two bits of the 3-bit select matter with four channels
   assign dbg_sel  = ctl0_q[DBG_SEL_LSB +: CHAN_SEL_W];

   always_ff @(posedge clk or negedge sync_rst_n)
      if (!sync_rst_n)
      begin
         ctl0_q  <= '0;
         status0 <= '0;
         id0     <= CL_ID0;
      end
      else
      begin
         ctl0_q  <= ctl0;
         status0 <= 32'(scrub_done);
         id0     <= dbg_en ? 32'(scrub_addr[dbg_sel]) : CL_ID0;
      end

   // flr done pulses, toggling while the request is held
   always_ff @(posedge clk or negedge sync_rst_n)
      if (!sync_rst_n)
      begin
         flr_q    <= 1'b0;
         flr_done <= 1'b0;
      end
      else
      begin
         flr_q    <= flr_assert;
         flr_done <= flr_q && !flr_done;
      end

endmodule

/* dram_dma_pkg.sv */
package dram_dma_pkg;

   // ---------------------------------------------------------------------
   // geometry
   // ---------------------------------------------------------------------
   localparam int NUM_CHAN   = 4;
   localparam int CHAN_SEL_W = 2;
   localparam int WORD_W     = 6;
   localparam int MEM_DEPTH  = 64;
   localparam int ADDR_W     = 8;
   localparam int DATA_W     = 32;

   // fifo depth and starting credit count on every link
   localparam int CREDITS = 4;

   // debug id and ctl0 field positions
   localparam logic [31:0] CL_ID0      = 32'hf000_1d0f;
   localparam int          DBG_EN_BIT  = 31;
   localparam int          DBG_SEL_LSB = 28;

   typedef logic [CHAN_SEL_W-1:0]            chan_sel_t;
   typedef logic [WORD_W-1:0]                word_t;
   typedef logic [ADDR_W-1:0]                addr_t;
   typedef logic [DATA_W-1:0]                data_t;
   // wide enough to hold CREDITS itself
   typedef logic [$clog2(CREDITS+1)-1:0]     credit_t;

   typedef struct packed {
      logic  write;
      word_t word;
      data_t data;
   } dram_cmd_t;

   typedef struct packed {
      word_t word;
      data_t data;
   } dram_rsp_t;

endpackage

/* dram_dma_top.sv */
`timescale 1ns/1ns

module dram_dma_top
   import dram_dma_pkg::*;
(
   input  logic        clk,
   input  logic        sync_rst_n,
   input  logic        cmd_valid,
   input  logic        cmd_write,
   input  addr_t       cmd_addr,
   input  data_t       cmd_data,
   output logic        cmd_ready,
   output logic        rd_rsp_valid,
   input  logic        rd_rsp_ready,
   output addr_t       rd_rsp_addr,
   output data_t       rd_rsp_data,
   input  logic [31:0] ctl0,
   input  logic        flr_assert,
   output logic        flr_done,
   output logic [31:0] status0,
   output logic [31:0] id0
);

   logic [NUM_CHAN-1:0] chan_valid;
   dram_cmd_t           chan_cmd;
   logic [NUM_CHAN-1:0] chan_credit;
   logic [NUM_CHAN-1:0] rsp_valid;
   dram_rsp_t           rsp [NUM_CHAN];
   logic [NUM_CHAN-1:0] rsp_credit;
   logic [NUM_CHAN-1:0] scrub_en;
   logic [NUM_CHAN-1:0] scrub_done;
   word_t               scrub_addr [NUM_CHAN];

   dma_cmd_router u_router (
      .clk         (clk),
      .sync_rst_n  (sync_rst_n),
      .cmd_valid   (cmd_valid),
      .cmd_write   (cmd_write),
      .cmd_addr    (cmd_addr),
      .cmd_data    (cmd_data),
      .cmd_ready   (cmd_ready),
      .chan_valid  (chan_valid),
      .chan_cmd    (chan_cmd),
      .chan_credit (chan_credit)
   );

   // ---------------------------------------------------------------------
   // channels
   // ---------------------------------------------------------------------
   for (genvar i = 0; i < NUM_CHAN; i++)
   begin : g_chan
      ddr_channel u_chan (
         .clk        (clk),
         .sync_rst_n (sync_rst_n),
         .cmd_valid  (chan_valid[i]),
         .cmd        (chan_cmd),
         .cmd_credit (chan_credit[i]),
         .scrub_en   (scrub_en[i]),
         .scrub_done (scrub_done[i]),
         .scrub_addr (scrub_addr[i]),
         .rsp_valid  (rsp_valid[i]),
         .rsp        (rsp[i]),
         .rsp_credit (rsp_credit[i])
      );
   end

   rsp_merge u_merge (
      .clk          (clk),
      .sync_rst_n   (sync_rst_n),
      .rsp_valid    (rsp_valid),
      .rsp          (rsp),
      .rsp_credit   (rsp_credit),
      .rd_rsp_valid (rd_rsp_valid),
      .rd_rsp_ready (rd_rsp_ready),
      .rd_rsp_addr  (rd_rsp_addr),
      .rd_rsp_data  (rd_rsp_data)
   );

   dram_ctl u_ctl (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .ctl0       (ctl0),
      .flr_assert (flr_assert),
      .flr_done   (flr_done),
      .scrub_en   (scrub_en),
      .scrub_done (scrub_done),
      .scrub_addr (scrub_addr),
      .status0    (status0),
      .id0        (id0)
   );

endmodule

/* rsp_merge.sv */
`timescale 1ns/1ns

module rsp_merge
   import dram_dma_pkg::*;
(
   input  logic                clk,
   input  logic                sync_rst_n,
   input  logic [NUM_CHAN-1:0] rsp_valid,
   input  dram_rsp_t           rsp [NUM_CHAN],
   output logic [NUM_CHAN-1:0] rsp_credit,
   output logic                rd_rsp_valid,
   input  logic                rd_rsp_ready,
   output addr_t               rd_rsp_addr,
   output data_t               rd_rsp_data
);

   dram_rsp_t           fifo_head [NUM_CHAN];
   logic [NUM_CHAN-1:0] fifo_empty;
   logic [NUM_CHAN-1:0] fifo_pop;
   chan_sel_t           rr_ptr;
   chan_sel_t           scan_idx;
   chan_sel_t           pick;
   logic                pick_found;
   logic                load;

   for (genvar i = 0; i < NUM_CHAN; i++)
   begin : g_fifo
      credit_fifo #(.payload_t(dram_rsp_t)) u_rsp_fifo (
         .clk        (clk),
         .sync_rst_n (sync_rst_n),
         .push       (rsp_valid[i]),
         .push_data  (rsp[i]),
         .pop        (fifo_pop[i]),
         .pop_data   (fifo_head[i]),
         .empty      (fifo_empty[i]),
         .credit     (rsp_credit[i])
      );
   end

   // round-robin search starting at rr_ptr
   always_comb
   begin
      pick_found = 1'b0;
      pick       = rr_ptr;
      scan_idx   = rr_ptr;
      for (int k = 0; k < NUM_CHAN; k++)
      begin
         scan_idx = chan_sel_t'(rr_ptr + k);
         if (!pick_found && !fifo_empty[scan_idx])
         begin
            pick_found = 1'b1;
            pick       = scan_idx;
         end
      end
   end

   // output slot is free or draining this cycle
   assign load = pick_found && (!rd_rsp_valid || rd_rsp_ready);

   always_comb
   begin
      fifo_pop = '0;
      if (load)
         fifo_pop[pick] = 1'b1;
   end

   always_ff @(posedge clk or negedge sync_rst_n)
      if (!sync_rst_n)
      begin
         rd_rsp_valid <= 1'b0;
         rr_ptr       <= '0;
      end
      else if (load)
      begin
         rd_rsp_valid <= 1'b1;
         rr_ptr       <= pick + 1'b1;
      end
      else if (rd_rsp_ready)
         rd_rsp_valid <= 1'b0;

   // channel index comes from which fifo the word sat in
   always_ff @(posedge clk)
      if (load)
      begin
         rd_rsp_addr <= {pick, fifo_head[pick].word};
         rd_rsp_data <= fifo_head[pick].data;
      end

   a_hold_stall: assert property (@(posedge clk) disable iff (!sync_rst_n)
      rd_rsp_valid && !rd_rsp_ready |=>
         rd_rsp_valid && $stable(rd_rsp_addr) && $stable(rd_rsp_data));

endmodule

/* src.f */
dram_dma_pkg.sv
credit_fifo.sv
dma_cmd_router.sv
ddr_channel.sv
rsp_merge.sv
dram_ctl.sv
dram_dma_top.sv
tb_dram_dma.sv

/* tb_dram_dma.sv */
`timescale 1ns/1ns

module tb_dram_dma
   import dram_dma_pkg::*;
;

   localparam int        CLK_PERIOD = 100;
   localparam int        READ_CNT   = 200;
   localparam chan_sel_t SCRUB_CHAN = 2'd2;
   // per test cycle budgets summed for the watchdog
   localparam int LIMIT_CYCLES = 20 + 2 * (256 + READ_CNT) + 100 + 6 * READ_CNT
                                 + 3 * (MEM_DEPTH + 20) + 3 * 2 * MEM_DEPTH + 20 + 500;

   logic        clk;
   logic        sync_rst_n;
   logic        cmd_valid;
   logic        cmd_write;
   addr_t       cmd_addr;
   data_t       cmd_data;
   logic        cmd_ready;
   logic        rd_rsp_valid;
   logic        rd_rsp_ready;
   addr_t       rd_rsp_addr;
   data_t       rd_rsp_data;
   logic [31:0] ctl0;
   logic        flr_assert;
   logic        flr_done;
   logic [31:0] status0;
   logic [31:0] id0;

   integer seed;
   integer ready_seed;
   integer rnd;
   integer ready_rnd;
   logic   stall_mode;
   int     errors;
   int     checks;
   int     tests_failed;
   int     issued;
   int     answered;
   int     err_mark;
   data_t  shadow [256];
   int     pending [256];
   logic   hold_prev;
   addr_t  prev_addr;
   data_t  prev_data;

   dram_dma_top uut (
      .clk          (clk),
      .sync_rst_n   (sync_rst_n),
      .cmd_valid    (cmd_valid),
      .cmd_write    (cmd_write),
      .cmd_addr     (cmd_addr),
      .cmd_data     (cmd_data),
      .cmd_ready    (cmd_ready),
      .rd_rsp_valid (rd_rsp_valid),
      .rd_rsp_ready (rd_rsp_ready),
      .rd_rsp_addr  (rd_rsp_addr),
      .rd_rsp_data  (rd_rsp_data),
      .ctl0         (ctl0),
      .flr_assert   (flr_assert),
      .flr_done     (flr_done),
      .status0      (status0),
      .id0          (id0)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   // expected read data is the last value written or zero after a scrub
   function data_t expected_data(input addr_t a);
      return shadow[a];
   endfunction

   // ----------------------------------------------------------------------
   // stimulus helpers
   // ----------------------------------------------------------------------
   task automatic send_cmd(input logic wr, input addr_t a, input data_t d);
      @(negedge clk);
      cmd_valid = 1'b1;
      cmd_write = wr;
      cmd_addr  = a;
      cmd_data  = d;
      @(posedge clk);
      while (!cmd_ready)
         @(posedge clk);
      if (wr)
         shadow[a] = d;
      else
      begin
         pending[a]++;
         issued++;
      end
   endtask

   task automatic wait_drain(input int limit);
      int n;
      n = 0;
      @(negedge clk);
      cmd_valid = 1'b0;
      while (issued != answered && n < limit)
      begin
         @(negedge clk);
         n++;
      end
      checks++;
      assert (issued == answered)
         else
         begin
            $display("%0d read responses never arrived by %0t", issued - answered, $time);
            errors++;
         end
   endtask

   task automatic check_value(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      assert (got === exp)
         else
         begin
            $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
         end
   endtask

   task automatic finish_test(input string name);
      if (errors == err_mark)
         $display("test %s: ok", name);
      else
      begin
         $display("test %s: FAILED with %0d errors", name, errors - err_mark);
         tests_failed++;
      end
      err_mark = errors;
   endtask

   // host back-pressure is random only while stall_mode is set
   always @(negedge clk)
   begin
      ready_rnd    = $random(ready_seed);
      rd_rsp_ready = stall_mode ? ready_rnd[0] : 1'b1;
   end

   // ----------------------------------------------------------------------
   // comparator samples the response port at the rising edge
   // ----------------------------------------------------------------------
   always @(posedge clk)
   begin
      if (sync_rst_n)
      begin
         if (hold_prev)
         begin
            checks++;
            assert (rd_rsp_valid && rd_rsp_addr == prev_addr && rd_rsp_data == prev_data)
               else
               begin
                  $display("mismatch at %0t: response changed while stalled", $time);
                  errors++;
               end
         end
         if (rd_rsp_valid && rd_rsp_ready)
         begin
            checks++;
            assert (pending[rd_rsp_addr] > 0)
               else
               begin
                  $display("response for address %h at %0t had no read waiting for it",
                           rd_rsp_addr, $time);
                  errors++;
               end
            if (pending[rd_rsp_addr] > 0)
            begin
               pending[rd_rsp_addr]--;
               answered++;
            end
            checks++;
            assert (rd_rsp_data == expected_data(rd_rsp_addr))
               else
               begin
                  $display("mismatch at %0t: addr %h data %h, expected %h", $time,
                           rd_rsp_addr, rd_rsp_data, expected_data(rd_rsp_addr));
                  errors++;
               end
         end
         hold_prev = rd_rsp_valid && !rd_rsp_ready;
         prev_addr = rd_rsp_addr;
         prev_data = rd_rsp_data;
      end
   end

   // watchdog
   initial
   begin
      repeat (LIMIT_CYCLES) @(posedge clk);
      $display("watchdog expired after %0d cycles, the run did not finish", LIMIT_CYCLES);
      $display("Verification failed");
      $finish;
   end

   // ----------------------------------------------------------------------
   // test sequence
   // ----------------------------------------------------------------------
   initial
   begin
      int n;
      clk          = 1'b0;
      sync_rst_n   = 1'b0;
      cmd_valid    = 1'b0;
      cmd_write    = 1'b0;
      cmd_addr     = '0;
      cmd_data     = '0;
      rd_rsp_ready = 1'b1;
      ctl0         = '0;
      flr_assert   = 1'b0;
      seed         = 32'hd5a2_7fcd;
      ready_seed   = ~32'hd5a2_7fcd;
      stall_mode   = 1'b0;
      errors       = 0;
      checks       = 0;
      tests_failed = 0;
      issued       = 0;
      answered     = 0;
      err_mark     = 0;
      hold_prev    = 1'b0;
      prev_addr    = '0;
      prev_data    = '0;
      for (int a = 0; a < 256; a++)
      begin
         shadow[a]  = '0;
         pending[a] = 0;
      end
      repeat (10) @(posedge clk);
      @(negedge clk);
      sync_rst_n = 1'b1;

      // idle state after reset
      @(negedge clk);
      check_value("rd_rsp_valid", 32'(rd_rsp_valid), 32'd0);
      check_value("flr_done", 32'(flr_done), 32'd0);
      check_value("status0", status0, 32'd0);
      check_value("id0", id0, CL_ID0);
      // full credits toward every channel
      check_value("cmd_ready", 32'(cmd_ready), 32'd1);
      finish_test("reset");

      // fill every word and read back at random
      for (int a = 0; a < 256; a++)
      begin
         rnd = $random(seed);
         send_cmd(1'b1, addr_t'(a), data_t'(rnd));
      end
      for (int r = 0; r < READ_CNT; r++)
      begin
         rnd = $random(seed);
         send_cmd(1'b0, rnd[7:0], '0);
      end
      wait_drain(200);
      finish_test("write_read");

      // random reads under host back-pressure
      stall_mode = 1'b1;
      for (int r = 0; r < READ_CNT; r++)
      begin
         rnd = $random(seed);
         send_cmd(1'b0, rnd[7:0], '0);
      end
      wait_drain(6 * READ_CNT);
      stall_mode = 1'b0;
      finish_test("backpressure");

      // scrub one channel
      @(negedge clk);
      ctl0[SCRUB_CHAN] = 1'b1;
      n = 0;
      while (!status0[SCRUB_CHAN] && n < MEM_DEPTH + 20)
      begin
         @(negedge clk);
         n++;
      end
      checks++;
      assert (status0[SCRUB_CHAN])
         else
         begin
            $display("scrub done flag never rose on channel %0d", SCRUB_CHAN);
            errors++;
         end
      for (int w = 0; w < MEM_DEPTH; w++)
         shadow[{SCRUB_CHAN, word_t'(w)}] = '0;
      ctl0[DBG_EN_BIT]                    = 1'b1;
      ctl0[DBG_SEL_LSB +: CHAN_SEL_W]     = SCRUB_CHAN;
      // ctl0 register and then id0 register
      repeat (2) @(negedge clk);
      check_value("id0 scrub address", id0, 32'(MEM_DEPTH - 1));
      for (int w = 0; w < MEM_DEPTH; w++)
         send_cmd(1'b0, {SCRUB_CHAN, word_t'(w)}, '0);
      for (int r = 0; r < MEM_DEPTH; r++)
      begin
         rnd = $random(seed);
         send_cmd(1'b0, rnd[7:0], '0);
      end
      wait_drain(3 * 2 * MEM_DEPTH);
      ctl0 = '0;
      finish_test("scrub");

      // flr response timing
      @(negedge clk);
      flr_assert = 1'b1;
      @(negedge clk);
      check_value("flr_done after first edge", 32'(flr_done), 32'd0);
      @(negedge clk);
      check_value("flr_done after second edge", 32'(flr_done), 32'd1);
      @(negedge clk);
      check_value("flr_done after third edge", 32'(flr_done), 32'd0);
      flr_assert = 1'b0;
      finish_test("flr");

      $display("tests: 5, failed: %0d, checks: %0d, errors: %0d",
               tests_failed, checks, errors);
      if (errors == 0)
         $display("Verification passed");
      else
         $display("Verification failed");
      $finish;
   end

endmodule
